/* bench/fpu_assertions.sv */
// fpu handshake assertions
`timescale 1ns/100ps

module fpu_assertions (
    input logic            clk,
    input logic            rst_n,
    input logic            issue_valid,
    input fpu_pkg::issue_t issue_instr,
    input logic            issue_ready,
    input logic            wb_valid,
    input fpu_pkg::wb_t    wb_data,
    input logic            wb_ready
);

    issue_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_instr))
        else $error("issue request dropped or changed before acceptance");

    wb_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_data))
        else $error("writeback record dropped or changed before acceptance");

    // queue must come out of reset empty
    wb_reset_a: assert property (@(posedge clk) !rst_n |=> !wb_valid)
        else $error("wb_valid high right after reset");

endmodule

bind fpu_top fpu_assertions asrt0 (.*);

/* bench/fpu_patterns.txt */
// register file r0..r31 at @000 and instruction count at @020
// rows from @040 hold opcode rs rt rd tag then expected rd result tag fault
@000
00000000 3f800000 40000000 40400000 3fc00000 bf800000 c0000000 80000000
3fa00000 40200000 3f400000 7f000000 00800000 3fffffff 3f800001 80800000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
@020
00000014
@040
22 03 04 01 0   01 40900000 0 0  // 3.0 * 1.5 renormalized
22 01 05 02 1   02 bf800000 1 0  // 1.0 * -1.0
22 08 0a 03 2   03 3f700000 2 0  // 1.25 * 0.75
22 06 09 04 3   04 c0a00000 3 0  // -2.0 * 2.5
22 0b 0b 05 4   05 7f800000 4 0  // overflow to infinity
22 0f 0c 06 5   06 80000000 5 0  // underflow keeps the sign
28 09 00 07 6   07 40c80000 6 0  // square of 2.5
28 00 03 08 7   08 00000000 7 0  // square of zero
28 0e 01 09 0   09 3f800002 0 0  // truncated low bits
28 0d 02 0a 1   0a 407ffffe 1 0  // largest mantissa squared
24 03 02 0b 2   0b ffffffff 2 0
24 02 03 0c 3   0c 00000000 3 0
24 01 06 0d 4   0d ffffffff 4 0  // positive over negative
25 06 05 0e 5   0e ffffffff 5 0  // both negative
25 05 01 0f 6   0f ffffffff 6 0
26 00 07 10 7   10 ffffffff 7 0  // +0 equals -0
27 00 07 11 0   11 00000000 0 0
27 03 05 12 1   12 ffffffff 1 0
20 01 02 13 2   13 00000000 2 1  // add is not supported
00 03 04 14 3   14 00000000 3 1

/* bench/fpu_tb.sv */
// fpu unit testbench
`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpu_tb;

    logic               clk;
    logic               rst_n;
    logic               issue_valid;
    fpu_pkg::issue_t    issue_instr;
    logic               issue_ready;
    fpu_pkg::reg_idx_t  rs_addr;
    fpu_pkg::reg_idx_t  rt_addr;
    fpu_pkg::word_t     rs_data;
    fpu_pkg::word_t     rt_data;
    logic               wb_valid;
    fpu_pkg::wb_t       wb_data;
    logic               wb_ready = 1'b0;

    logic [`FPU_DATA_W-1:0] pat [0:511];  // raw pattern image
    fpu_pkg::word_t     regs [0:31];
    fpu_pkg::issue_t    instrs [0:31];
    fpu_pkg::wb_t       expected [0:31];
    int                 n_instr;
    int                 n_recv = 0;
    int                 check_errors = 0;
    int                 run_errors;
    int                 cycle = 0;
    int                 first_issue = -1;
    int                 first_wb = -1;
    logic               random_phase;
    logic [31:0]        rng = 32'hc5cc;

    fpu_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_ready (issue_ready),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .wb_ready    (wb_ready)
    );

    assign rs_data = regs[rs_addr];  // register file read ports
    assign rt_data = regs[rt_addr];

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_patterns();
        int r;
        int i;
        int b;
        $readmemh("bench/fpu_patterns.txt", pat);
        n_instr = int'(pat[32]);
        if (n_instr < 1 || n_instr > 32) begin
            $display("pattern file holds no usable instruction count");
            run_errors++;
            n_instr = 0;
        end
        for (r = 0; r < 32; r++) begin
            regs[r] = pat[r];
        end
        for (i = 0; i < n_instr; i++) begin
            b = 64 + 9 * i;                  // nine words per row
            instrs[i] = {pat[b][5:0], pat[b+1][4:0], pat[b+2][4:0],
                         pat[b+3][4:0], pat[b+4][2:0]};
            expected[i] = {pat[b+5][4:0], pat[b+6], pat[b+7][2:0], pat[b+8][0]};
        end
    endtask

    task automatic issue_all(input logic with_gaps);
        int i;
        for (i = 0; i < n_instr; i++) begin
            while (with_gaps && rng[17:16] == 2'd0) begin
                issue_valid <= 1'b0;         // idle cycle
                @(posedge clk);
            end
            issue_valid <= 1'b1;
            issue_instr <= instrs[i];
            @(posedge clk);
            while (!issue_ready) begin
                @(posedge clk);
            end
        end
        issue_valid <= 1'b0;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED record %0d %s got %h expected %h", n_recv, name, got, want);
            check_errors++;
        end
    endtask

    task automatic check_record();
        fpu_pkg::wb_t want;
        if (n_recv >= 2 * n_instr) begin
            $display("writeback record %0d arrived after the last instruction", n_recv);
            check_errors++;
        end else begin
            want = expected[n_recv % n_instr];  // second pass repeats the list
            compare_field("wb_data.rd", 32'(wb_data.rd), 32'(want.rd));
            compare_field("wb_data.result", wb_data.result, want.result);
            compare_field("wb_data.tag", 32'(wb_data.tag), 32'(want.tag));
            compare_field("wb_data.fault", 32'(wb_data.fault), 32'(want.fault));
        end
        n_recv++;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        rng      <= lcg_next(rng);
        wb_ready <= !random_phase || (rng[21:20] != 2'd0);  // drops one cycle in four
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle = cycle + 1;
            if (issue_valid && issue_ready && first_issue < 0) begin
                first_issue = cycle;
            end
            if (wb_valid && first_wb < 0) begin
                first_wb = cycle;
            end
            if (wb_valid && wb_ready) begin
                check_record();
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue_instr = '0;
        random_phase = 1'b0;
        run_errors = 0;
        load_patterns();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        issue_all(1'b0);                     // back to back with wb_ready high
        wait (n_recv == n_instr);
        if (first_wb - first_issue != 3) begin
            $display("wb_valid rose %0d cycles after the first issue instead of 3",
                     first_wb - first_issue);
            run_errors++;
        end
        random_phase <= 1'b1;
        issue_all(1'b1);
        wait (n_recv == 2 * n_instr);
        repeat (20) @(posedge clk);
        if (n_recv != 2 * n_instr || wb_valid) begin
            $display("writeback output kept going after the last instruction");
            run_errors++;
        end
        $display("check errors %0d run errors %0d records %0d of %0d",
                 check_errors, run_errors, n_recv, 2 * n_instr);
        if (check_errors == 0 && run_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #1;
        repeat (2 * n_instr * 20 + 200) @(posedge clk);
        $display("watchdog expired with the writeback output stalled at %0d of %0d records",
                 n_recv, 2 * n_instr);
        $display("Test failed");
        $finish;
    end

endmodule

/* design/fpu_consts.svh */
// fpu unit constants
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// kept opcodes
`define FPU_OP_FMUL 6'b100010  // rs * rt
`define FPU_OP_FSQR 6'b101000  // rs * rs in the legacy FAND encoding
`define FPU_OP_FGT  6'b100100  // rs > rt
`define FPU_OP_FLT  6'b100101  // rs < rt
`define FPU_OP_FEQ  6'b100110  // rs == rt
`define FPU_OP_FNE  6'b100111  // rs != rt

// field widths
`define FPU_OPC_W   6
`define FPU_REG_W   5
`define FPU_TAG_W   3          // scheduler slot
`define FPU_DATA_W  32

// single precision bias
`define FPU_EXP_BIAS 127

`endif

/* design/fpu_decode.sv */
// fpu decode stage
`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpu_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  fpu_pkg::issue_t    issue_instr,
    output logic               issue_ready,
    output fpu_pkg::reg_idx_t  rs_addr,
    output fpu_pkg::reg_idx_t  rt_addr,
    input  fpu_pkg::word_t     rs_data,
    input  fpu_pkg::word_t     rt_data,
    output logic               dec_valid,
    output fpu_pkg::decoded_t  dec_data,
    input  logic               dec_ready
);

    fpu_pkg::fpu_func_e func;
    fpu_pkg::decoded_t  dec_next;
    logic               square;

    assign rs_addr = issue_instr.rs;             // register file answers same cycle
    assign rt_addr = issue_instr.rt;
    assign issue_ready = dec_ready || !dec_valid; // advance when empty or draining

    always_comb begin
        square = 1'b0;
        case (issue_instr.opcode)
            `FPU_OP_FMUL: func = fpu_pkg::FN_MUL;
            `FPU_OP_FSQR: begin
                func   = fpu_pkg::FN_MUL;
                square = 1'b1;                   // rt ignored
            end
            `FPU_OP_FGT:  func = fpu_pkg::FN_GT;
            `FPU_OP_FLT:  func = fpu_pkg::FN_LT;
            `FPU_OP_FEQ:  func = fpu_pkg::FN_EQ;
            `FPU_OP_FNE:  func = fpu_pkg::FN_NE;
            default:      func = fpu_pkg::FN_FAULT;
        endcase
    end

    always_comb begin
        dec_next.func   = func;
        dec_next.opnd_a = rs_data;
        dec_next.opnd_b = square ? rs_data : rt_data;
        dec_next.rd     = issue_instr.rd;
        dec_next.tag    = issue_instr.tag;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (issue_ready) begin
            dec_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            dec_data <= dec_next;                // payload only on transfer
        end
    end

endmodule

/* design/fpu_execute.sv */
// fpu execute stage
`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpu_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dec_valid,
    input  fpu_pkg::decoded_t  dec_data,
    output logic               dec_ready,
    output logic               exe_valid,
    output fpu_pkg::wb_t       exe_data,
    input  logic               exe_ready
);

    fpu_pkg::word_t a;
    fpu_pkg::word_t b;
    fpu_pkg::word_t mul_res;
    fpu_pkg::wb_t   exe_next;
    logic           a_zero;
    logic           b_zero;
    logic           sign_p;
    logic [23:0]    man_a;
    logic [23:0]    man_b;
    logic [47:0]    prod;
    logic [22:0]    frac;
    logic [9:0]     exp_raw;
    logic [9:0]     exp_res;
    logic           sa;
    logic           sb;
    logic [30:0]    mag_a;
    logic [30:0]    mag_b;
    logic           eq;
    logic           gt;

    assign a = dec_data.opnd_a;
    assign b = dec_data.opnd_b;
    assign a_zero = (a[30:23] == 8'd0);          // denormals flush to zero
    assign b_zero = (b[30:23] == 8'd0);

    // truncating multiplier
    assign sign_p  = a[31] ^ b[31];
    assign man_a   = {1'b1, a[22:0]};
    assign man_b   = {1'b1, b[22:0]};
    assign prod    = man_a * man_b;
    assign frac    = prod[47] ? prod[46:24] : prod[45:23]; // renormalize at >= 2.0
    assign exp_raw = {2'b00, a[30:23]} + {2'b00, b[30:23]} + {9'd0, prod[47]};
    assign exp_res = exp_raw - 10'(`FPU_EXP_BIAS);

    always_comb begin
        if (a_zero || b_zero) begin
            mul_res = {sign_p, 31'd0};
        end else if (exp_raw >= 10'(255 + `FPU_EXP_BIAS)) begin
            mul_res = {sign_p, 8'hff, 23'd0};    // overflow to infinity
        end else if (exp_raw <= 10'(`FPU_EXP_BIAS)) begin
            mul_res = {sign_p, 31'd0};           // underflow to zero
        end else begin
            mul_res = {sign_p, exp_res[7:0], frac};
        end
    end

    // compare by sign and magnitude with both zeros equal
    assign sa    = a[31] && !a_zero;
    assign sb    = b[31] && !b_zero;
    assign mag_a = a_zero ? 31'd0 : a[30:0];
    assign mag_b = b_zero ? 31'd0 : b[30:0];
    assign eq    = (sa == sb) && (mag_a == mag_b);
    assign gt    = (sa != sb) ? !sa : (sa ? (mag_a < mag_b) : (mag_a > mag_b));

    always_comb begin
        exe_next.rd    = dec_data.rd;
        exe_next.tag   = dec_data.tag;
        exe_next.fault = 1'b0;
        case (dec_data.func)
            fpu_pkg::FN_MUL: exe_next.result = mul_res;
            fpu_pkg::FN_GT:  exe_next.result = {32{gt}};
            fpu_pkg::FN_LT:  exe_next.result = {32{!gt && !eq}};
            fpu_pkg::FN_EQ:  exe_next.result = {32{eq}};
            fpu_pkg::FN_NE:  exe_next.result = {32{!eq}};
            default: begin
                exe_next.result = 32'd0;
                exe_next.fault  = 1'b1;          // completes without a result
            end
        endcase
    end

    assign dec_ready = exe_ready || !exe_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else if (dec_ready) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            exe_data <= exe_next;
        end
    end

endmodule

/* design/fpu_pkg.sv */
// fpu unit types
`include "fpu_consts.svh"

package fpu_pkg;

    typedef logic [`FPU_OPC_W-1:0]  opcode_t;
    typedef logic [`FPU_REG_W-1:0]  reg_idx_t;
    typedef logic [`FPU_TAG_W-1:0]  slot_tag_t;
    typedef logic [`FPU_DATA_W-1:0] word_t;

    typedef enum logic [2:0] {
        FN_MUL,
        FN_GT,
        FN_LT,
        FN_EQ,
        FN_NE,
        FN_FAULT          // unsupported opcode
    } fpu_func_e;

    typedef struct packed {
        opcode_t   opcode;
        reg_idx_t  rs;
        reg_idx_t  rt;
        reg_idx_t  rd;
        slot_tag_t tag;
    } issue_t;

    typedef struct packed {
        fpu_func_e func;
        word_t     opnd_a;
        word_t     opnd_b;
        reg_idx_t  rd;
        slot_tag_t tag;
    } decoded_t;

    typedef struct packed {
        reg_idx_t  rd;
        word_t     result;
        slot_tag_t tag;
        logic      fault;  // set for unsupported opcode
    } wb_t;

endpackage

/* design/fpu_result.sv */
// fpu writeback queue
`timescale 1ns/100ps

module fpu_result (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          exe_valid,
    input  fpu_pkg::wb_t  exe_data,
    output logic          exe_ready,
    output logic          wb_valid,
    output fpu_pkg::wb_t  wb_data,
    input  logic          wb_ready
);

    fpu_pkg::wb_t queue [0:1];  // two deep in issue order
    logic         wr_ptr;
    logic         rd_ptr;
    logic [1:0]   count;
    logic         push;
    logic         pop;

    assign exe_ready = (count != 2'd2);
    assign wb_valid  = (count != 2'd0);
    assign wb_data   = queue[rd_ptr];     // head record

    assign push = exe_valid && exe_ready;
    assign pop  = wb_valid && wb_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;  // idle or pass-through
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= exe_data;
        end
    end

endmodule

/* design/fpu_top.sv */
// fpu issue unit top
`timescale 1ns/100ps

module fpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  fpu_pkg::issue_t    issue_instr,
    output logic               issue_ready,
    output fpu_pkg::reg_idx_t  rs_addr,
    output fpu_pkg::reg_idx_t  rt_addr,
    input  fpu_pkg::word_t     rs_data,
    input  fpu_pkg::word_t     rt_data,
    output logic               wb_valid,
    output fpu_pkg::wb_t       wb_data,
    input  logic               wb_ready
);

    logic              dec_valid;
    logic              dec_ready;
    fpu_pkg::decoded_t dec_data;
    logic              exe_valid;
    logic              exe_ready;
    fpu_pkg::wb_t      exe_data;

    fpu_decode decode0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_ready (issue_ready),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .dec_valid   (dec_valid),
        .dec_data    (dec_data),
        .dec_ready   (dec_ready)
    );

    fpu_execute execute0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_data  (dec_data),
        .dec_ready (dec_ready),
        .exe_valid (exe_valid),
        .exe_data  (exe_data),
        .exe_ready (exe_ready)
    );

    fpu_result result0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_valid (exe_valid),
        .exe_data  (exe_data),
        .exe_ready (exe_ready),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data),
        .wb_ready  (wb_ready)
    );

endmodule

/* project.f */
+incdir+design
design/fpu_pkg.sv
design/fpu_decode.sv
design/fpu_execute.sv
design/fpu_result.sv
design/fpu_top.sv
bench/fpu_assertions.sv
bench/fpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fpu testbench with verilator
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --timing --assert --top-module fpu_tb -Mdir obj_dir -o fpu_sim -f project.f; then
    echo "verilator build failed"
    exit 1
fi
./obj_dir/fpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
